// File: Bender.yml
package:
  name: utlb

sources:
  - include_dirs:
      - include
    files:
      - hdl/utlb_pkg.sv
      - hdl/utlb_store_if.sv
      - hdl/dp_ram.sv
      - hdl/mem_inv_block.sv
      - hdl/utlb_stats.sv
      - hdl/utlb_ctrl.sv
      - hdl/utlb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/utlb_checker.sv
      - bench/tb_utlb.sv

// File: bench/tb_utlb.sv
// Micro-TLB testbench

`default_nettype none

`include "utlb_defs.svh"

module tb_utlb;

localparam int CLK_PERIOD   = 8;
localparam int RESET_CYCLES = 5;
localparam int MAX_WAIT     = 16;
localparam int RAND_OPS     = 200;
// The directed tests issue under 100 transfers, a random op at most three.
localparam int N_XFERS      = 100 + 3 * RAND_OPS;

logic        clk;
logic        reset;
logic        psel;
logic        penable;
logic        pwrite;
logic [7:0]  paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        pready;
logic        pslverr;
int          chk_count;
int          chk_errors;
int          bus_errors = 0;
int          errs_at_start = 0;
int          test_num = 0;
integer      seed;

utlb_top u_dut (
        .i_clk     ( clk ),
        .i_reset   ( reset ),
        .i_psel    ( psel ),
        .i_penable ( penable ),
        .i_pwrite  ( pwrite ),
        .i_paddr   ( paddr ),
        .i_pwdata  ( pwdata ),
        .o_prdata  ( prdata ),
        .o_pready  ( pready ),
        .o_pslverr ( pslverr )
);

utlb_checker u_chk (
        .i_clk     ( clk ),
        .i_reset   ( reset ),
        .i_psel    ( psel ),
        .i_penable ( penable ),
        .i_pwrite  ( pwrite ),
        .i_paddr   ( paddr ),
        .i_pwdata  ( pwdata ),
        .i_prdata  ( prdata ),
        .i_pready  ( pready ),
        .i_pslverr ( pslverr ),
        .o_checks  ( chk_count ),
        .o_errors  ( chk_errors )
);

initial
begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Watchdog over the whole run.
initial
begin
        #((RESET_CYCLES + N_XFERS * 10) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in %0d clock periods", N_XFERS * 10);
        $display("Test failed");
        $finish;
end

// ----------------------------------------
// APB driver
// ----------------------------------------

// Setup phase, then access phase until pready. Inputs move on the falling edge.
task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready && waited < MAX_WAIT)
        begin
                waited++;
                @(posedge clk);
        end
        if (!pready)
        begin
                bus_errors++;
                $display("Transfer to offset %02h got no pready in %0d cycles", addr, MAX_WAIT);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        apb_transfer(1'b1, addr, data);
endtask

task automatic read_reg(input logic [7:0] addr);
        apb_transfer(1'b0, addr, 32'd0);
endtask

task automatic fill_entry(input logic [`UTLB_VPN_W-1:0] vpn, input logic [31:0] ppn);
        write_reg(`UTLB_REG_FILL_VPN, 32'(vpn));
        write_reg(`UTLB_REG_FILL_PPN, ppn);
endtask

// A lookup is always followed by a RESULT read so the checker sees it.
task automatic look_up(input logic [`UTLB_VPN_W-1:0] vpn);
        write_reg(`UTLB_REG_LOOKUP, 32'(vpn));
        read_reg(`UTLB_REG_RESULT);
endtask

task automatic read_counts();
        read_reg(`UTLB_REG_HITS);
        read_reg(`UTLB_REG_MISSES);
endtask

task automatic report_test(input string name);
        int now_errs;
        now_errs = chk_errors + bus_errors;
        test_num++;
        if (now_errs == errs_at_start)
                $display("test %0d %s: ok", test_num, name);
        else
                $display("test %0d %s: %0d errors", test_num, name, now_errs - errs_at_start);
        errs_at_start = now_errs;
endtask

// ----------------------------------------
// Test sequences
// ----------------------------------------

initial
begin
        logic [31:0]            r;
        logic [`UTLB_VPN_W-1:0] vpn;
        seed    = 32'h58343ff7;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // An empty table misses everything.
        read_counts();
        read_reg(`UTLB_REG_RESULT);
        look_up(20'h00000);
        look_up(20'h12345);
        look_up(20'hFFFFF);
        read_counts();
        report_test("reset_state");

        fill_entry(20'hABCD5, 32'h0001234A);
        fill_entry(20'h00010, 32'hFFF55555);
        fill_entry(20'h7777F, 32'h000FFFFF);
        look_up(20'hABCD5);
        look_up(20'h00010);
        look_up(20'h7777F);
        read_counts();
        report_test("fill_hit");

        // Same row 3, different tags.
        fill_entry(20'h11113, 32'h0000AAAA);
        look_up(20'h22223);
        look_up(20'h11113);
        fill_entry(20'h22223, 32'h0000BBBB);
        look_up(20'h11113);
        look_up(20'h22223);
        read_counts();
        report_test("alias");

        fill_entry(20'h40001, 32'h00011111);
        fill_entry(20'h40002, 32'h00022222);
        fill_entry(20'h5000E, 32'h000EEEEE);
        fill_entry(20'h6000F, 32'h000FFFF0);
        look_up(20'h40001);
        look_up(20'h5000E);
        look_up(20'h6000F);
        look_up(20'h40002);
        write_reg(`UTLB_REG_CTRL, 32'h1);
        look_up(20'h40001);
        look_up(20'h40002);
        look_up(20'h5000E);
        look_up(20'h6000F);
        read_counts();
        write_reg(`UTLB_REG_CTRL, 32'h2);
        read_counts();
        report_test("invalidate_clear");

        // Two tags over 16 rows keep both hits and misses common.
        for (int i = 0; i < RAND_OPS; i++)
        begin
                r   = $random(seed);
                vpn = {(r[0] ? 16'hBEEF : 16'h0042), r[7:4]};
                if (r[9:8] == 2'd0)
                        fill_entry(vpn, $random(seed));
                else
                        look_up(vpn);
                if (i % 8 == 7)
                        read_counts();
        end
        read_counts();
        report_test("random");

        fill_entry(20'h3C3C9, 32'h00099999);
        write_reg(8'h1C, 32'hFFFFFFFF);
        write_reg(8'h20, 32'h00000003);
        read_reg(8'h40);
        read_reg(`UTLB_REG_RESULT);
        look_up(20'h3C3C9);
        read_counts();
        report_test("unknown_offset");

        $display("%0d checks passed, %0d errors", chk_count - chk_errors, chk_errors + bus_errors);
        if (chk_errors + bus_errors == 0)
                $display("Test passed");
        else
                $display("Test failed");
        $finish;
end

endmodule

`default_nettype wire

// File: bench/utlb_checker.sv
// Micro-TLB bus checker

`default_nettype none

`include "utlb_defs.svh"

module utlb_checker
        import utlb_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_psel,
        input  logic        i_penable,
        input  logic        i_pwrite,
        input  logic [7:0]  i_paddr,
        input  logic [31:0] i_pwdata,
        input  logic [31:0] i_prdata,
        input  logic        i_pready,
        input  logic        i_pslverr,
        output int          o_checks,
        output int          o_errors
);

// Shadow copy of the translation table and of the software-visible state.
logic [`UTLB_DEPTH-1:0] sh_valid;
tag_t                   sh_tag [`UTLB_DEPTH];
logic [`UTLB_PPN_W-1:0] sh_ppn [`UTLB_DEPTH];
logic [`UTLB_VPN_W-1:0] sh_fill_vpn;
logic [31:0]            sh_result;
logic [15:0]            sh_hits;
logic [15:0]            sh_misses;
logic [31:0]            wait_cnt;
int                     checks = 0;
int                     errors = 0;

assign o_checks = checks;
assign o_errors = errors;

// Expected RESULT word for a key: the low bits pick the row, the rest must
// match the stored tag of a valid row. A miss reads as all zeros.
function automatic logic [31:0] expected_result(input logic [`UTLB_VPN_W-1:0] vpn);
        logic [`UTLB_IDX_W-1:0] idx;
        idx = vpn[`UTLB_IDX_W-1:0];
        if (sh_valid[idx] && sh_tag[idx] == vpn[`UTLB_VPN_W-1:`UTLB_IDX_W])
                return {1'b1, {(31-`UTLB_PPN_W){1'b0}}, sh_ppn[idx]};
        return 32'd0;
endfunction

function automatic logic known_offset(input logic [7:0] addr);
        case (addr)
        `UTLB_REG_CTRL, `UTLB_REG_FILL_VPN, `UTLB_REG_FILL_PPN, `UTLB_REG_LOOKUP,
        `UTLB_REG_RESULT, `UTLB_REG_HITS, `UTLB_REG_MISSES: return 1'b1;
        default: return 1'b0;
        endcase
endfunction

// A lookup stretches its write by four wait states while the stores' read
// pipeline runs. Every other transfer completes without a wait state.
function automatic logic [31:0] expected_waits(input logic wr, input logic [7:0] addr);
        if (wr && addr == `UTLB_REG_LOOKUP)
                return 32'd4;
        return 32'd0;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp)
        begin
                errors++;
                $display("ERR %s expected 0x%0h got 0x%0h", name, exp, got);
        end
endtask

// Applies a completed write to the shadow state.
task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
        logic [`UTLB_IDX_W-1:0] idx;
        idx = sh_fill_vpn[`UTLB_IDX_W-1:0];
        case (addr)
        `UTLB_REG_CTRL:
        begin
                if (data[0])
                        sh_valid = '0;
                if (data[1])
                begin
                        sh_hits   = '0;
                        sh_misses = '0;
                end
        end
        `UTLB_REG_FILL_VPN: sh_fill_vpn = data[`UTLB_VPN_W-1:0];
        `UTLB_REG_FILL_PPN:
        begin
                sh_valid[idx] = 1'b1;
                sh_tag[idx]   = sh_fill_vpn[`UTLB_VPN_W-1:`UTLB_IDX_W];
                sh_ppn[idx]   = data[`UTLB_PPN_W-1:0];
        end
        `UTLB_REG_LOOKUP:
        begin
                sh_result = expected_result(data[`UTLB_VPN_W-1:0]);
                // Counters saturate at all ones.
                if (sh_result[31] && sh_hits != 16'hFFFF)
                        sh_hits = sh_hits + 16'd1;
                else if (!sh_result[31] && sh_misses != 16'hFFFF)
                        sh_misses = sh_misses + 16'd1;
        end
        default: ;
        endcase
endtask

// ----------------------------------------
// Bus monitor
// ----------------------------------------

// A transfer completes on the edge where psel, penable and pready are high.
// Sampling here sees the values from before the edge.
always @(posedge i_clk)
begin
        if (i_reset)
        begin
                sh_valid    = '0;
                sh_fill_vpn = '0;
                sh_result   = '0;
                sh_hits     = '0;
                sh_misses   = '0;
                wait_cnt    = '0;
        end
        else if (i_psel && i_penable)
        begin
                if (!i_pready)
                        wait_cnt = wait_cnt + 32'd1;
                else
                begin
                        check_value("pready wait", expected_waits(i_pwrite, i_paddr),
                                    wait_cnt);
                        wait_cnt = '0;
                        check_value("pslverr", {31'd0, !known_offset(i_paddr)},
                                    {31'd0, i_pslverr});
                        if (i_pwrite)
                                apply_write(i_paddr, i_pwdata);
                        else
                        begin
                                case (i_paddr)
                                `UTLB_REG_RESULT:
                                        check_value("RESULT", sh_result, i_prdata);
                                `UTLB_REG_HITS:
                                        check_value("HITS", {16'd0, sh_hits}, i_prdata);
                                `UTLB_REG_MISSES:
                                        check_value("MISSES", {16'd0, sh_misses}, i_prdata);
                                default: ;
                                endcase
                        end
                end
        end
end

endmodule

`default_nettype wire

// File: hdl/dp_ram.sv
// Simple dual-port RAM

`default_nettype none

module dp_ram #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = 16
)(
        input  logic                     i_clk,
        input  logic                     i_clken,
        input  logic                     i_wr_en,
        input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
        input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
        input  payload_t                 i_wr_data,
        output payload_t                 o_rd_data_pre,
        output payload_t                 o_rd_data
);

localparam int AW = $clog2(DEPTH);

payload_t      mem [DEPTH];
logic [AW-1:0] rd_addr_q;
logic [AW-1:0] rd_addr_q2;

// Write port. A write lands in the array at the edge it is presented.
always_ff @(posedge i_clk)
begin
        if (i_clken && i_wr_en)
        begin
                mem[i_wr_addr] <= i_wr_data;
        end
end

// The read address is registered first, then carried along so that each
// later stage knows which row it holds.
always_ff @(posedge i_clk)
begin
        if (i_clken)
        begin
                rd_addr_q  <= i_rd_addr;
                rd_addr_q2 <= rd_addr_q;
        end
end

// Read register and output register.
// A write to the row held at a stage replaces that stage's data, so a read
// never returns a value older than the last write to its row.
always_ff @(posedge i_clk)
begin
        if (i_clken)
        begin
                o_rd_data_pre <= (i_wr_en && i_wr_addr == rd_addr_q) ?
                                 i_wr_data : mem[rd_addr_q];
                o_rd_data     <= (i_wr_en && i_wr_addr == rd_addr_q2) ?
                                 i_wr_data : o_rd_data_pre;
        end
end

endmodule

`default_nettype wire

// File: hdl/mem_inv_block.sv
// Invalidatable RAM store

`default_nettype none

module mem_inv_block #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = 16
)(
        input logic             i_clk,
        input logic             i_reset,
        utlb_store_if.store     bus
);

localparam int AW = $clog2(DEPTH);

// One valid flip-flop per row. Keeping these out of the RAM lets a single
// edge clear the whole table.
logic [DEPTH-1:0] dav_q;

// Row addresses as they move down the valid pipeline.
logic [AW-1:0]    raddr_del;
logic [AW-1:0]    raddr_del2;
logic             rdav_st1;

// Set when the write in this cycle hits the row held at that stage.
logic             conflict_st1;
logic             conflict_st2;
logic             conflict_st3;

// The payload lives in a plain RAM. It runs the same two and three stage
// read timing as the valid pipeline below.
dp_ram #(
        .payload_t ( payload_t ),
        .DEPTH     ( DEPTH )
) u_ram (
        .i_clk         ( i_clk ),
        .i_clken       ( bus.clken ),
        .i_wr_en       ( bus.wen ),
        .i_wr_addr     ( bus.waddr ),
        .i_rd_addr     ( bus.raddr ),
        .i_wr_data     ( bus.wdata ),
        .o_rd_data_pre ( bus.rdata_pre ),
        .o_rd_data     ( bus.rdata )
);

// ----------------------------------------
// Valid bits
// ----------------------------------------

// Invalidate wins over a write. The controller never issues both together.
always_ff @(posedge i_clk)
begin
        if (i_reset || bus.inv)
        begin
                dav_q <= '0;
        end
        else if (bus.clken && bus.wen)
        begin
                dav_q[bus.waddr] <= 1'b1;
        end
end

// ----------------------------------------
// Valid pipeline
// ----------------------------------------

assign conflict_st1 = bus.wen && bus.waddr == bus.raddr;
assign conflict_st2 = bus.wen && bus.waddr == raddr_del;
assign conflict_st3 = bus.wen && bus.waddr == raddr_del2;

// Each stage takes the valid of the row it holds, or forces it high when
// that row is being written, matching the data forwarding in the RAM.
// An invalidate drops every stage at once.
always_ff @(posedge i_clk)
begin
        if (i_reset || bus.inv)
        begin
                raddr_del    <= '0;
                raddr_del2   <= '0;
                rdav_st1     <= 1'b0;
                bus.rdav_pre <= 1'b0;
                bus.rdav     <= 1'b0;
        end
        else if (bus.clken)
        begin
                raddr_del    <= bus.raddr;
                raddr_del2   <= raddr_del;
                rdav_st1     <= conflict_st1 ? 1'b1 : dav_q[bus.raddr];
                bus.rdav_pre <= conflict_st2 ? 1'b1 : rdav_st1;
                bus.rdav     <= conflict_st3 ? 1'b1 : bus.rdav_pre;
        end
end

// ----------------------------------------
// Checks
// ----------------------------------------

// Invalidate and fill come from different registers, so they must never meet.
assert property (@(posedge i_clk) disable iff (i_reset)
        !(bus.inv && bus.wen))
        else $error("store saw invalidate and write in the same cycle");

// Once the pipeline has refilled from the cleared valid bits, a row that
// nobody wrote since the invalidate must still read as invalid.
assert property (@(posedge i_clk) disable iff (i_reset)
        bus.inv ##1 (!bus.wen) [*3] |=> !bus.rdav_pre && !bus.rdav)
        else $error("store read valid survived an invalidate");

endmodule

`default_nettype wire

// File: hdl/utlb_ctrl.sv
// Micro-TLB controller

`default_nettype none

`include "utlb_defs.svh"

module utlb_ctrl
        import utlb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_psel,
        input  logic            i_penable,
        input  logic            i_pwrite,
        input  logic [7:0]      i_paddr,
        input  logic [31:0]     i_pwdata,
        output logic [31:0]     o_prdata,
        output logic            o_pready,
        output logic            o_pslverr,
        utlb_store_if.ctrl      tag_bus,
        utlb_store_if.ctrl      data_bus,
        output logic            o_hit_pulse,
        output logic            o_miss_pulse,
        output logic            o_stat_clear,
        input  logic [15:0]     i_hits,
        input  logic [15:0]     i_misses
);

ctrl_state_t            state_q;
ctrl_state_t            state_d;
logic                   acc;
logic                   wr_acc;
logic                   known_addr;
logic                   look_start;
logic                   fill_setup;
logic                   fill_go;
logic                   final_hit;
logic [`UTLB_VPN_W-1:0] fill_vpn_q;
tag_t                   look_tag_q;
logic [2:0]             look_pipe_q;
logic                   tag_hit_q;
logic                   result_hit_q;
logic [`UTLB_PPN_W-1:0] result_ppn_q;

// ----------------------------------------
// APB decode
// ----------------------------------------

assign acc        = i_psel && i_penable;
assign wr_acc     = acc && i_pwrite;
assign look_start = wr_acc && i_paddr == `UTLB_REG_LOOKUP && state_q == IDLE;
assign fill_setup = i_psel && !i_penable && i_pwrite && i_paddr == `UTLB_REG_FILL_PPN;
assign fill_go    = wr_acc && i_paddr == `UTLB_REG_FILL_PPN && state_q == FILL;

// Only a lookup stretches the transfer. DONE releases it.
assign o_pready  = !(look_start || state_q == LOOK_WAIT);
assign o_pslverr = acc && !known_addr;

// Register read mux. Unknown offsets return zero.
always_comb
begin
        known_addr = 1'b1;
        o_prdata   = '0;
        case (i_paddr)
        `UTLB_REG_CTRL, `UTLB_REG_FILL_PPN, `UTLB_REG_LOOKUP: o_prdata = '0;
        `UTLB_REG_FILL_VPN: o_prdata = 32'(fill_vpn_q);
        `UTLB_REG_RESULT:
                o_prdata = {result_hit_q, {(31-`UTLB_PPN_W){1'b0}}, result_ppn_q};
        `UTLB_REG_HITS:     o_prdata = {16'd0, i_hits};
        `UTLB_REG_MISSES:   o_prdata = {16'd0, i_misses};
        default:            known_addr = 1'b0;
        endcase
end

// ----------------------------------------
// Store requests
// ----------------------------------------

// The stores run every cycle. Both see the same address and enables so
// that the tag and the translation of a row always travel together.
assign tag_bus.clken  = 1'b1;
assign data_bus.clken = 1'b1;
assign tag_bus.wen    = fill_go;
assign data_bus.wen   = fill_go;
assign tag_bus.waddr  = fill_vpn_q[`UTLB_IDX_W-1:0];
assign data_bus.waddr = fill_vpn_q[`UTLB_IDX_W-1:0];
assign tag_bus.wdata  = fill_vpn_q[`UTLB_VPN_W-1:`UTLB_IDX_W];
assign data_bus.wdata = entry_t'{ppn: i_pwdata[`UTLB_PPN_W-1:0]};

// The lookup index is taken straight from the bus in the access cycle.
assign tag_bus.raddr  = i_pwdata[`UTLB_IDX_W-1:0];
assign data_bus.raddr = i_pwdata[`UTLB_IDX_W-1:0];

// Bit 0 of a CTRL write drops every entry. Bit 1 clears the counters.
assign tag_bus.inv    = wr_acc && i_paddr == `UTLB_REG_CTRL && i_pwdata[0];
assign data_bus.inv   = wr_acc && i_paddr == `UTLB_REG_CTRL && i_pwdata[0];
assign o_stat_clear   = wr_acc && i_paddr == `UTLB_REG_CTRL && i_pwdata[1];

// ----------------------------------------
// Lookup pipeline and FSM
// ----------------------------------------

// A hit needs a tag match at the pre stage and a valid entry at the end.
assign final_hit    = tag_hit_q && data_bus.rdav;
assign o_hit_pulse  = look_pipe_q[2] && final_hit;
assign o_miss_pulse = look_pipe_q[2] && !final_hit;

always_comb
begin
        state_d = state_q;
        case (state_q)
        IDLE:
        begin
                if (look_start)
                        state_d = LOOK_WAIT;
                else if (fill_setup)
                        state_d = FILL;
        end
        FILL:      if (fill_go || !i_psel) state_d = IDLE;
        LOOK_WAIT: if (look_pipe_q[2]) state_d = DONE;
        DONE:      if (acc) state_d = IDLE;
        default:   state_d = IDLE;
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q      <= IDLE;
                look_pipe_q  <= '0;
                tag_hit_q    <= 1'b0;
                result_hit_q <= 1'b0;
                result_ppn_q <= '0;
                fill_vpn_q   <= '0;
        end
        else
        begin
                state_q     <= state_d;
                look_pipe_q <= {look_pipe_q[1:0], look_start};
                if (wr_acc && i_paddr == `UTLB_REG_FILL_VPN)
                        fill_vpn_q <= i_pwdata[`UTLB_VPN_W-1:0];
                if (look_pipe_q[1])
                        tag_hit_q <= tag_bus.rdav_pre && tag_bus.rdata_pre == look_tag_q;
                // A miss reports a zero translation.
                if (look_pipe_q[2])
                begin
                        result_hit_q <= final_hit;
                        result_ppn_q <= final_hit ? data_bus.rdata.ppn : '0;
                end
        end
end

// The tag to compare is held for the whole lookup.
always_ff @(posedge i_clk)
begin
        if (look_start)
                look_tag_q <= i_pwdata[`UTLB_VPN_W-1:`UTLB_IDX_W];
end

// A lookup holds the bus for four cycles at most.
assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(o_pready) |-> ##[1:4] o_pready)
        else $error("pready held low for more than four cycles");

endmodule

`default_nettype wire

// File: hdl/utlb_pkg.sv
// Micro-TLB types

`default_nettype none

`include "utlb_defs.svh"

package utlb_pkg;

        // ----------------------------------------
        // Stored payloads
        // ----------------------------------------

        // The tag is the part of the virtual page number above the index.
        // The index itself selects the row and is never stored.
        typedef logic [`UTLB_VPN_W-`UTLB_IDX_W-1:0] tag_t;

        // One translation entry. Only the physical page number is held
        // for now, but keeping it in a struct leaves room for attributes.
        typedef struct packed {
                logic [`UTLB_PPN_W-1:0] ppn;
        } entry_t;

        // ----------------------------------------
        // Controller FSM
        // ----------------------------------------

        // IDLE waits for a transfer.
        // FILL is entered from the setup phase of a FILL_PPN write.
        // LOOK_WAIT follows a lookup down the store pipeline.
        // DONE holds the registered result while pready completes the write.
        typedef enum logic [1:0] {
                IDLE      = 2'd0,
                FILL      = 2'd1,
                LOOK_WAIT = 2'd2,
                DONE      = 2'd3
        } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/utlb_stats.sv
// Hit and miss counters

`default_nettype none

module utlb_stats (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_hit,
        input  logic        i_miss,
        input  logic        i_clear,
        output logic [15:0] o_hits,
        output logic [15:0] o_misses
);

// Both counters stick at all ones instead of wrapping, so software can tell
// an overflowed count from a small one.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_hits   <= '0;
                o_misses <= '0;
        end
        else
        begin
                if (i_hit && o_hits != '1)
                begin
                        o_hits <= o_hits + 16'd1;
                end
                if (i_miss && o_misses != '1)
                begin
                        o_misses <= o_misses + 16'd1;
                end
        end
end

endmodule

`default_nettype wire

// File: hdl/utlb_store_if.sv
// Controller to store bus

`default_nettype none

`include "utlb_defs.svh"

interface utlb_store_if #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = `UTLB_DEPTH
);

        // Request side, driven by the controller.
        logic                     clken;
        logic                     wen;
        logic [$clog2(DEPTH)-1:0] waddr;
        logic [$clog2(DEPTH)-1:0] raddr;
        payload_t                 wdata;
        logic                     inv;

        // Response side, driven by the store.
        // The _pre pair is one stage ahead of the final pair.
        payload_t                 rdata_pre;
        logic                     rdav_pre;
        payload_t                 rdata;
        logic                     rdav;

        modport ctrl (
                output clken, wen, waddr, raddr, wdata, inv,
                input  rdata_pre, rdav_pre, rdata, rdav
        );

        modport store (
                input  clken, wen, waddr, raddr, wdata, inv,
                output rdata_pre, rdav_pre, rdata, rdav
        );

endinterface

`default_nettype wire

// File: hdl/utlb_top.sv
// Micro-TLB top level

`default_nettype none

`include "utlb_defs.svh"

module utlb_top
        import utlb_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_psel,
        input  logic        i_penable,
        input  logic        i_pwrite,
        input  logic [7:0]  i_paddr,
        input  logic [31:0] i_pwdata,
        output logic [31:0] o_prdata,
        output logic        o_pready,
        output logic        o_pslverr
);

logic        hit_pulse;
logic        miss_pulse;
logic        stat_clear;
logic [15:0] hits;
logic [15:0] misses;

// Separate buses for tags and translations. Both share one row index.
utlb_store_if #(.payload_t(tag_t),   .DEPTH(`UTLB_DEPTH)) tag_bus ();
utlb_store_if #(.payload_t(entry_t), .DEPTH(`UTLB_DEPTH)) data_bus ();

utlb_ctrl u_ctrl (
        .i_clk        ( i_clk ),
        .i_reset      ( i_reset ),
        .i_psel       ( i_psel ),
        .i_penable    ( i_penable ),
        .i_pwrite     ( i_pwrite ),
        .i_paddr      ( i_paddr ),
        .i_pwdata     ( i_pwdata ),
        .o_prdata     ( o_prdata ),
        .o_pready     ( o_pready ),
        .o_pslverr    ( o_pslverr ),
        .tag_bus      ( tag_bus ),
        .data_bus     ( data_bus ),
        .o_hit_pulse  ( hit_pulse ),
        .o_miss_pulse ( miss_pulse ),
        .o_stat_clear ( stat_clear ),
        .i_hits       ( hits ),
        .i_misses     ( misses )
);

utlb_stats u_stats (
        .i_clk    ( i_clk ),
        .i_reset  ( i_reset ),
        .i_hit    ( hit_pulse ),
        .i_miss   ( miss_pulse ),
        .i_clear  ( stat_clear ),
        .o_hits   ( hits ),
        .o_misses ( misses )
);

mem_inv_block #(.payload_t(tag_t), .DEPTH(`UTLB_DEPTH)) u_tag_store (
        .i_clk   ( i_clk ),
        .i_reset ( i_reset ),
        .bus     ( tag_bus )
);

mem_inv_block #(.payload_t(entry_t), .DEPTH(`UTLB_DEPTH)) u_data_store (
        .i_clk   ( i_clk ),
        .i_reset ( i_reset ),
        .bus     ( data_bus )
);

endmodule

`default_nettype wire

// File: include/utlb_defs.svh
// Micro-TLB shared definitions

`ifndef UTLB_DEFS_SVH
`define UTLB_DEFS_SVH

// Geometry of the translation cache.
`define UTLB_DEPTH 16
`define UTLB_VPN_W 20
`define UTLB_PPN_W 20
`define UTLB_IDX_W 4

// APB register offsets.
`define UTLB_REG_CTRL     8'h00
`define UTLB_REG_FILL_VPN 8'h04
`define UTLB_REG_FILL_PPN 8'h08
`define UTLB_REG_LOOKUP   8'h0C
`define UTLB_REG_RESULT   8'h10
`define UTLB_REG_HITS     8'h14
`define UTLB_REG_MISSES   8'h18

`endif

// File: vlog.f
+incdir+include
hdl/utlb_pkg.sv
hdl/utlb_store_if.sv
hdl/dp_ram.sv
hdl/mem_inv_block.sv
hdl/utlb_stats.sv
hdl/utlb_ctrl.sv
hdl/utlb_top.sv
bench/utlb_checker.sv
bench/tb_utlb.sv
